// File: project.f
src/blink_scan_pkg.sv
src/line_pixel_timing.sv
src/spot_window_detector.sv
src/blink_period_classifier.sv
src/result_sequencer.sv
src/blink_analyzer_top.sv
bench/blink_analyzer_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f project.f \
    --top-module blink_analyzer_tb -o blink_analyzer_sim

output=$(./obj_dir/blink_analyzer_sim)
echo "$output"

echo "$output" | grep -q "Simulation passed"

// File: bench/blink_analyzer_tb.sv
module blink_analyzer_tb
    import blink_scan_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_LENGTH   = 48;
    localparam int THRESHOLD     = 96;
    localparam int DEVIATION     = 1;
    localparam int WIN_START [3] = '{4, 18, 32};
    localparam int WIN_STOP  [3] = '{12, 26, 40};
    localparam int PERIOD0   [3] = '{4, 5, 6};
    localparam int PERIOD1   [3] = '{8, 9, 11};
    localparam int STYLE_SOLID   = 0;
    localparam int STYLE_RANDOM  = 1;
    localparam int STYLE_SPIKE   = 2;
    localparam int MAX_LINES     = 64;
    localparam int TOTAL_LINES   = 40 + 40 + 30 + 20 + 20;
    localparam int TIMEOUT_CYCLES = TOTAL_LINES * LINE_LENGTH * 2 + 500;

    logic          pixel_clock = 1'b0;
    logic          rst;
    logic          start;
    logic          stop;
    pixel_t        pixel;
    result_t       result;
    result_index_t result_index;
    logic          result_valid;
    logic          done;

    pixel_t  line_pix [LINE_LENGTH];
    logic    line_bits [3][MAX_LINES];
    int      spot_style [3];
    int      spot_period [3];
    int      outside_period;
    result_t expected_words [RESULT_COUNT];
    int      readouts_requested = 0;
    int      readouts_finished = 0;
    int      word_count = 0;
    int      error_count = 0;
    int      cycle_count = 0;
    int      errors_seen = 0;
    int      test_count = 0;
    int      tests_failed = 0;

    blink_analyzer_top #(
        .LINE_LENGTH(LINE_LENGTH), .THRESHOLD(THRESHOLD), .DEVIATION(DEVIATION),
        .POINT0_START(4), .POINT0_STOP(12), .POINT1_START(18), .POINT1_STOP(26),
        .POINT2_START(32), .POINT2_STOP(40),
        .POINT0_PERIOD0(4), .POINT0_PERIOD1(8), .POINT1_PERIOD0(5), .POINT1_PERIOD1(9),
        .POINT2_PERIOD0(6), .POINT2_PERIOD1(11)
    ) DUT (
        .pixel_clock(pixel_clock), .rst(rst), .start(start), .stop(stop), .pixel(pixel),
        .result(result), .result_index(result_index), .result_valid(result_valid),
        .done(done)
    );

    always #20 pixel_clock = ~pixel_clock;

    always @(posedge pixel_clock)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, readout never finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // scene generation
    ////////////////////

    function automatic logic scheduled_bit(input int period, input int line);
        if (period <= 0)
            return 1'b0;
        return (line % period) < (period / 2);
    endfunction

    // bright when the midpoint of the extremes is above the threshold
    function automatic logic window_bright(input int spot);
        pixel_t hi;
        pixel_t lo;
        pixel_t mid;
        int     p;
        hi = '0;
        lo = '1;
        for (p = WIN_START[spot]; p < WIN_STOP[spot]; p++)
        begin
            if (line_pix[p] > hi)
                hi = line_pix[p];
            if (line_pix[p] < lo)
                lo = line_pix[p];
        end
        mid = lo + ((hi - lo) >> 1);
        return int'(mid) > THRESHOLD;
    endfunction

    task automatic build_line(input int line);
        int   spot;
        int   p;
        int   spike_at;
        int   lo;
        int   hi;
        logic bright;
        // background blinks on its own schedule when a period is set
        bright = scheduled_bit(outside_period, line);
        for (p = 0; p < LINE_LENGTH; p++)
        begin
            if (outside_period == 0)
                line_pix[p] = pixel_t'($urandom % 256);
            else
                line_pix[p] = bright ? pixel_t'(200 + int'($urandom % 56))
                                     : pixel_t'($urandom % 41);
        end
        for (spot = 0; spot < 3; spot++)
        begin
            bright   = scheduled_bit(spot_period[spot], line);
            spike_at = WIN_START[spot] + int'($urandom % (WIN_STOP[spot] - WIN_START[spot]));
            // solid windows sit wholly above or below the threshold
            lo = 97 + int'($urandom % 100);
            hi = int'($urandom % 97);
            for (p = WIN_START[spot]; p < WIN_STOP[spot]; p++)
            begin
                case (spot_style[spot])
                    STYLE_RANDOM: line_pix[p] = pixel_t'($urandom % 256);
                    STYLE_SPIKE:  line_pix[p] = (bright && p == spike_at)
                                              ? pixel_t'(200 + int'($urandom % 56))
                                              : pixel_t'($urandom % 41);
                    default:      line_pix[p] = bright
                                              ? pixel_t'(lo + int'($urandom % (256 - lo)))
                                              : pixel_t'($urandom % (hi + 1));
                endcase
            end
            if (spot_style[spot] == STYLE_RANDOM)
                bright = window_bright(spot);
            line_bits[spot][line] = bright;
        end
    endtask

    task automatic set_spot(input int spot, input int style, input int period);
        spot_style[spot]  = style;
        spot_period[spot] = period;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // kind 0 time0, 1 time1, 2 unknown
    function automatic result_t predict_word(input int spot, input int kind, input int lines);
        int      i;
        int      last_edge;
        int      period;
        int      dist0;
        int      dist1;
        logic    armed;
        logic    prev;
        result_t total;
        last_edge = 0;
        armed     = 1'b0;
        prev      = 1'b0;
        total     = '0;
        for (i = 0; i < lines; i++)
        begin
            if (line_bits[spot][i] && !prev)
            begin
                if (armed)
                begin
                    period = i - last_edge;
                    dist0  = (period > PERIOD0[spot]) ? period - PERIOD0[spot]
                                                      : PERIOD0[spot] - period;
                    dist1  = (period > PERIOD1[spot]) ? period - PERIOD1[spot]
                                                      : PERIOD1[spot] - period;
                    if (dist0 <= DEVIATION)
                    begin
                        if (kind == 0)
                            total = total + result_t'(period);
                    end
                    else if (dist1 <= DEVIATION)
                    begin
                        if (kind == 1)
                            total = total + result_t'(period);
                    end
                    else if (kind == 2)
                        total = total + result_t'(period);
                end
                armed     = 1'b1;
                last_edge = i;
            end
            prev = line_bits[spot][i];
        end
        return total;
    endfunction

    task automatic load_expected(input int lines);
        int i;
        for (i = 0; i < 6; i++)
            expected_words[i] = predict_word(i / 2, i % 2, lines);
        for (i = 0; i < 3; i++)
            expected_words[6 + i] = predict_word(i, 2, lines);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic issue_stop();
        @(posedge pixel_clock);
        pixel <= '0;
        stop  <= 1'b1;
        readouts_requested++;
        @(posedge pixel_clock);
        stop  <= 1'b0;
    endtask

    task automatic run_scene(input int lines);
        int line;
        int p;
        @(posedge pixel_clock);
        start <= 1'b1;
        for (line = 0; line < lines; line++)
        begin
            build_line(line);
            for (p = 0; p < LINE_LENGTH; p++)
            begin
                @(posedge pixel_clock);
                start <= 1'b0;
                pixel <= line_pix[p];
            end
        end
        load_expected(lines);
        issue_stop();
    endtask

    task automatic end_test(input string name);
        wait (readouts_finished == readouts_requested);
        repeat (2) @(posedge pixel_clock);
        test_count++;
        if (error_count == errors_seen)
            $display("test %0d (%s): passed", test_count, name);
        else
        begin
            tests_failed++;
            $display("test %0d (%s): failed, %0d errors", test_count, name,
                     error_count - errors_seen);
        end
        errors_seen = error_count;
    endtask

    initial
    begin
        void'($urandom(32'h226baccf));
        rst   <= 1'b1;
        start <= 1'b0;
        stop  <= 1'b0;
        pixel <= '0;
        outside_period = 0;
        repeat (16) @(posedge pixel_clock);
        rst <= 1'b0;
        @(posedge pixel_clock);

        set_spot(0, STYLE_SOLID, 4);
        set_spot(1, STYLE_SOLID, 5);
        set_spot(2, STYLE_SOLID, 11);
        run_scene(40);
        end_test("spot0 blinking at period 4");

        set_spot(0, STYLE_SOLID, 0);
        set_spot(1, STYLE_SOLID, 9);
        set_spot(2, STYLE_SOLID, 3);
        run_scene(40);
        end_test("spot1 period 9, spot2 period 3");

        // single bright pixel over a dark window
        set_spot(0, STYLE_SPIKE, 4);
        set_spot(1, STYLE_RANDOM, 0);
        set_spot(2, STYLE_RANDOM, 0);
        run_scene(30);
        end_test("midpoint rule on random windows");

        issue_stop();
        end_test("stop while idle reads last values");

        set_spot(0, STYLE_SOLID, 8);
        set_spot(1, STYLE_SOLID, 0);
        set_spot(2, STYLE_SOLID, 6);
        run_scene(20);
        end_test("second start clears accumulators");

        set_spot(0, STYLE_SOLID, 0);
        set_spot(1, STYLE_SOLID, 0);
        set_spot(2, STYLE_SOLID, 0);
        outside_period = 4;
        run_scene(20);
        end_test("bright background, dark windows");

        $display("%0d tests, %0d failed, %0d errors", test_count, tests_failed, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // readout checking
    ////////////////////

    always @(posedge pixel_clock)
    begin
        if (!rst)
        begin
            if (result_valid)
            begin
                if (readouts_finished == readouts_requested || word_count >= RESULT_COUNT)
                begin
                    $display("at %0t a result word came outside a readout", $time);
                    error_count++;
                end
                else
                begin
                    if (result_index !== result_index_t'(word_count))
                    begin
                        $display("Mismatch at %0t: result_index expected %0d, got %0d",
                                 $time, word_count, result_index);
                        error_count++;
                    end
                    if (result !== expected_words[word_count])
                    begin
                        $display("Mismatch at %0t: result[%0d] expected %0d, got %0d",
                                 $time, word_count, expected_words[word_count], result);
                        error_count++;
                    end
                    word_count++;
                end
            end
            else if (word_count > 0 && word_count < RESULT_COUNT)
            begin
                $display("at %0t the readout broke off after %0d words", $time, word_count);
                error_count++;
            end
            if (done)
            begin
                if (word_count != RESULT_COUNT)
                begin
                    $display("at %0t done came after %0d words instead of %0d",
                             $time, word_count, RESULT_COUNT);
                    error_count++;
                end
                word_count = 0;
                readouts_finished++;
            end
            else if (word_count == RESULT_COUNT && !result_valid)
            begin
                $display("at %0t done did not follow the ninth word", $time);
                error_count++;
                word_count = 0;
                readouts_finished++;
            end
        end
    end

endmodule

// File: src/blink_analyzer_top.sv
module blink_analyzer_top
    import blink_scan_pkg::*;
#(
    parameter int LINE_LENGTH    = 1040,
    parameter int POINT0_START   = 18,
    parameter int POINT0_STOP    = 50,
    parameter int POINT1_START   = 272,
    parameter int POINT1_STOP    = 304,
    parameter int POINT2_START   = 784,
    parameter int POINT2_STOP    = 816,
    parameter int THRESHOLD      = 96,
    parameter int POINT0_PERIOD0 = 4,
    parameter int POINT0_PERIOD1 = 8,
    parameter int POINT1_PERIOD0 = 12,
    parameter int POINT1_PERIOD1 = 16,
    parameter int POINT2_PERIOD0 = 20,
    parameter int POINT2_PERIOD1 = 24,
    parameter int DEVIATION      = 1
)
(
    input  logic          pixel_clock,
    input  logic          rst,
    input  logic          start,
    input  logic          stop,
    input  pixel_t        pixel,
    output result_t       result,
    output result_index_t result_index,
    output logic          result_valid,
    output logic          done
);

    pixel_t       pixel_out;
    logic         pixel_valid;
    pixel_index_t pixel_index;
    logic         line_start;

    logic    spot0_sample, spot1_sample, spot2_sample;
    logic    spot0_strobe, spot1_strobe, spot2_strobe;
    result_t p0_time0, p0_time1, p0_unknown;
    result_t p1_time0, p1_time1, p1_unknown;
    result_t p2_time0, p2_time1, p2_unknown;

    ////////////////////
    // input side
    ////////////////////

    line_pixel_timing #(.LINE_LENGTH(LINE_LENGTH)) timing (
        .pixel_clock(pixel_clock), .rst(rst), .start(start), .stop(stop), .pixel(pixel),
        .pixel_out(pixel_out), .pixel_valid(pixel_valid), .pixel_index(pixel_index),
        .line_start(line_start)
    );

    ////////////////////
    // spot windows
    ////////////////////

    spot_window_detector #(.START(POINT0_START), .STOP(POINT0_STOP), .THRESHOLD(THRESHOLD))
    spot0 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start), .pixel_out(pixel_out),
        .pixel_valid(pixel_valid), .pixel_index(pixel_index),
        .sample(spot0_sample), .sample_strobe(spot0_strobe)
    );

    spot_window_detector #(.START(POINT1_START), .STOP(POINT1_STOP), .THRESHOLD(THRESHOLD))
    spot1 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start), .pixel_out(pixel_out),
        .pixel_valid(pixel_valid), .pixel_index(pixel_index),
        .sample(spot1_sample), .sample_strobe(spot1_strobe)
    );

    spot_window_detector #(.START(POINT2_START), .STOP(POINT2_STOP), .THRESHOLD(THRESHOLD))
    spot2 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start), .pixel_out(pixel_out),
        .pixel_valid(pixel_valid), .pixel_index(pixel_index),
        .sample(spot2_sample), .sample_strobe(spot2_strobe)
    );

    ////////////////////
    // blink classifiers
    ////////////////////

    blink_period_classifier #(
        .PERIOD0(POINT0_PERIOD0), .PERIOD1(POINT0_PERIOD1), .DEVIATION(DEVIATION)
    ) classifier0 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start),
        .sample(spot0_sample), .sample_strobe(spot0_strobe),
        .time0(p0_time0), .time1(p0_time1), .unknown(p0_unknown)
    );

    blink_period_classifier #(
        .PERIOD0(POINT1_PERIOD0), .PERIOD1(POINT1_PERIOD1), .DEVIATION(DEVIATION)
    ) classifier1 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start),
        .sample(spot1_sample), .sample_strobe(spot1_strobe),
        .time0(p1_time0), .time1(p1_time1), .unknown(p1_unknown)
    );

    blink_period_classifier #(
        .PERIOD0(POINT2_PERIOD0), .PERIOD1(POINT2_PERIOD1), .DEVIATION(DEVIATION)
    ) classifier2 (
        .pixel_clock(pixel_clock), .rst(rst), .line_start(line_start),
        .sample(spot2_sample), .sample_strobe(spot2_strobe),
        .time0(p2_time0), .time1(p2_time1), .unknown(p2_unknown)
    );

    // readout after stop
    result_sequencer readout (
        .pixel_clock(pixel_clock), .rst(rst), .stop(stop),
        .p0_time0(p0_time0), .p0_time1(p0_time1), .p1_time0(p1_time0),
        .p1_time1(p1_time1), .p2_time0(p2_time0), .p2_time1(p2_time1),
        .p0_unknown(p0_unknown), .p1_unknown(p1_unknown), .p2_unknown(p2_unknown),
        .result(result), .result_index(result_index), .result_valid(result_valid),
        .done(done)
    );

endmodule

// File: src/result_sequencer.sv
module result_sequencer
    import blink_scan_pkg::*;
(
    input  logic          pixel_clock,
    input  logic          rst,
    input  logic          stop,
    input  result_t       p0_time0,
    input  result_t       p0_time1,
    input  result_t       p1_time0,
    input  result_t       p1_time1,
    input  result_t       p2_time0,
    input  result_t       p2_time1,
    input  result_t       p0_unknown,
    input  result_t       p1_unknown,
    input  result_t       p2_unknown,
    output result_t       result,
    output result_index_t result_index,
    output logic          result_valid,
    output logic          done
);

    // let the last line strobe reach the accumulators
    localparam logic [3:0] FIRST_STEP = 4'd3;
    localparam logic [3:0] DONE_STEP  = 4'(3 + RESULT_COUNT);

    logic       busy;
    logic [3:0] step;

    assign result_valid = busy && (step >= FIRST_STEP) && (step < DONE_STEP);
    assign done         = busy && (step == DONE_STEP);
    assign result_index = result_index_t'(step - FIRST_STEP);

    ////////////////////
    // step counter
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            step <= '0;
        end
        else if (!busy)
        begin
            if (stop)
            begin
                busy <= 1'b1;
                step <= 4'd1;
            end
        end
        else if (step == DONE_STEP)
        begin
            busy <= 1'b0;
            step <= '0;
        end
        else
        begin
            step <= step + 1'b1;
        end
    end

    // periods first, then the unknowns
    always_comb
    begin
        case (result_index)
            4'd0:    result = p0_time0;
            4'd1:    result = p0_time1;
            4'd2:    result = p1_time0;
            4'd3:    result = p1_time1;
            4'd4:    result = p2_time0;
            4'd5:    result = p2_time1;
            4'd6:    result = p0_unknown;
            4'd7:    result = p1_unknown;
            4'd8:    result = p2_unknown;
            default: result = '0;
        endcase
    end

endmodule

// File: src/blink_period_classifier.sv
module blink_period_classifier
    import blink_scan_pkg::*;
#(
    parameter int PERIOD0   = 4,
    parameter int PERIOD1   = 8,
    parameter int DEVIATION = 1
)
(
    input  logic    pixel_clock,
    input  logic    rst,
    input  logic    line_start,
    input  logic    sample,
    input  logic    sample_strobe,
    output result_t time0,
    output result_t time1,
    output result_t unknown
);

    logic        prev_sample;
    logic        armed;
    logic        rising;
    line_count_t line_count;
    result_t     period;

    // true when a period is within DEVIATION of a nominal value
    function automatic logic near(input line_count_t measured, input int nominal);
        int diff;
        diff = int'(measured) - nominal;
        return (diff >= -DEVIATION) && (diff <= DEVIATION);
    endfunction

    assign rising = sample_strobe & sample & ~prev_sample;
    assign period = result_t'(line_count);

    ////////////////////
    // edge and period
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst || line_start)
        begin
            prev_sample <= 1'b0;
            armed       <= 1'b0;
            line_count  <= '0;
        end
        else if (sample_strobe)
        begin
            prev_sample <= sample;
            if (rising)
            begin
                // edge strobe itself is the first line of the next period
                armed      <= 1'b1;
                line_count <= line_count_t'(1);
            end
            else if (line_count != '1)
            begin
                line_count <= line_count + 1'b1;
            end
        end
    end

    ////////////////////
    // accumulators
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst || line_start)
        begin
            time0   <= '0;
            time1   <= '0;
            unknown <= '0;
        end
        else if (rising && armed)
        begin
            // first match wins
            if (near(line_count, PERIOD0))
                time0 <= time0 + period;
            else if (near(line_count, PERIOD1))
                time1 <= time1 + period;
            else
                unknown <= unknown + period;
        end
    end

endmodule

// File: src/spot_window_detector.sv
module spot_window_detector
    import blink_scan_pkg::*;
#(
    parameter int START     = 18,
    parameter int STOP      = 50,
    parameter int THRESHOLD = 96
)
(
    input  logic         pixel_clock,
    input  logic         rst,
    input  logic         line_start,
    input  pixel_t       pixel_out,
    input  logic         pixel_valid,
    input  pixel_index_t pixel_index,
    output logic         sample,
    output logic         sample_strobe
);

    localparam pixel_index_t FIRST_INDEX = pixel_index_t'(START);
    localparam pixel_index_t STOP_INDEX  = pixel_index_t'(STOP);
    localparam pixel_t       LEVEL       = pixel_t'(THRESHOLD);

    pixel_t max_value;
    pixel_t min_value;
    pixel_t delta;
    pixel_t midpoint;
    logic   in_window;
    logic   at_stop;

    assign in_window = pixel_valid && (pixel_index >= FIRST_INDEX) && (pixel_index < STOP_INDEX);
    assign at_stop   = pixel_valid && (pixel_index == STOP_INDEX);

    // midpoint of the extremes, not the mean
    assign delta    = max_value - min_value;
    assign midpoint = min_value + (delta >> 1);

    ////////////////////
    // window extremes
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst || line_start || at_stop)
        begin
            max_value <= '0;
            min_value <= '1;
        end
        else if (in_window)
        begin
            if (pixel_out > max_value)
                max_value <= pixel_out;
            if (pixel_out < min_value)
                min_value <= pixel_out;
        end
    end

    // one decision per line
    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            sample_strobe <= 1'b0;
        end
        else
        begin
            sample_strobe <= at_stop;
        end
    end

    always_ff @(posedge pixel_clock)
    begin
        if (at_stop)
        begin
            sample <= (midpoint > LEVEL);
        end
    end

endmodule

// File: src/line_pixel_timing.sv
module line_pixel_timing
    import blink_scan_pkg::*;
#(
    parameter int LINE_LENGTH = 1040
)
(
    input  logic         pixel_clock,
    input  logic         rst,
    input  logic         start,
    input  logic         stop,
    input  pixel_t       pixel,
    output pixel_t       pixel_out,
    output logic         pixel_valid,
    output pixel_index_t pixel_index,
    output logic         line_start
);

    localparam pixel_index_t LAST_INDEX = pixel_index_t'(LINE_LENGTH - 1);

    logic         acquiring;
    logic         take;
    pixel_index_t next_index;

    // start only counts while idle, stop wins
    assign line_start = start & ~acquiring & ~stop;
    assign take       = acquiring & ~stop;

    ////////////////////
    // acquisition flag
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            acquiring <= 1'b0;
        end
        else if (stop)
        begin
            acquiring <= 1'b0;
        end
        else if (line_start)
        begin
            acquiring <= 1'b1;
        end
    end

    ////////////////////
    // pixel register and index
    ////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            pixel_valid <= 1'b0;
            next_index  <= '0;
        end
        else
        begin
            pixel_valid <= take;
            if (line_start)
            begin
                next_index <= '0;
            end
            else if (take)
            begin
                // wrap at end of line
                if (next_index == LAST_INDEX)
                    next_index <= '0;
                else
                    next_index <= next_index + 1'b1;
            end
        end
    end

    always_ff @(posedge pixel_clock)
    begin
        pixel_out   <= pixel;
        pixel_index <= next_index;
    end

endmodule

// File: src/blink_scan_pkg.sv
package blink_scan_pkg;

    // one sensor sample
    typedef logic [7:0] pixel_t;

    // position within a line
    typedef logic [10:0] pixel_index_t;

    // blink period in lines, saturates at all ones
    typedef logic [15:0] line_count_t;

    // one accumulated value
    typedef logic [31:0] result_t;

    ////////////////////
    // readout
    ////////////////////

    // three spots, time0 + time1 + unknown each
    localparam int RESULT_COUNT = 9;

    typedef logic [3:0] result_index_t;

endpackage
